// ==== hdl/rasterCmd_config.svh ====
// Rasterizer command parser configuration
// Word width, opcode values, header field sizes and register indices
`ifndef RASTERCMD_CONFIG_SVH
`define RASTERCMD_CONFIG_SVH

`define CMD_WIDTH 32

`define OP_POS  28
`define OP_SIZE 4

`define OP_NOP           4'd0
`define OP_TRIANGLE      4'd1
`define OP_TEXTURE       4'd2
`define OP_FOG_LUT       4'd3
`define OP_RENDER_CONFIG 4'd4
`define OP_FRAMEBUFFER   4'd5

// Header field widths
`define TRI_COUNT_SIZE  18
`define TEX_FORMAT_SIZE 5
`define TEX_SIZE_SIZE   5
`define CFG_INDEX_SIZE  4

`define CFG_REG_COUNT 14
`define FOG_LUT_WORDS 33

`define CFG_IDX_FEATURE_ENABLE     0
`define CFG_IDX_FRAGMENT_PIPE      1
`define CFG_IDX_FOG_COLOR          2
`define CFG_IDX_TMU0_TEX_ENV       3
`define CFG_IDX_TMU0_TEX_CONFIG    4
`define CFG_IDX_TMU0_TEX_ENV_COLOR 5
`define CFG_IDX_TMU1_TEX_ENV       6
`define CFG_IDX_TMU1_TEX_CONFIG    7
`define CFG_IDX_TMU1_TEX_ENV_COLOR 8
`define CFG_IDX_SCISSOR_START      9
`define CFG_IDX_SCISSOR_END        10
`define CFG_IDX_Y_OFFSET           11
`define CFG_IDX_CLEAR_COLOR        12
`define CFG_IDX_CLEAR_DEPTH        13

`endif

// ==== hdl/rasterCmdPkg.sv ====
// Rasterizer command parser types
// Header word layouts, stream beats, buffer commands and render configuration
`include "rasterCmd_config.svh"

package rasterCmdPkg;

    // One view of the header word per opcode
    typedef union packed {
        struct packed {
            logic [`OP_SIZE-1:0]                   opcode;
            logic [`OP_POS-`TRI_COUNT_SIZE-1:0]    pad;
            logic [`TRI_COUNT_SIZE-1:0]            byteCount;
        } triangle;
        struct packed {
            logic [`OP_SIZE-1:0]                   opcode;
            logic [`OP_POS-1-`TEX_FORMAT_SIZE-`TEX_SIZE_SIZE-1:0] pad;
            logic                                  tmuNr;
            logic [`TEX_FORMAT_SIZE-1:0]           pixelFormat;
            logic [`TEX_SIZE_SIZE-1:0]             sizeLog2;
        } texture;
        struct packed {
            logic [`OP_SIZE-1:0]                   opcode;
            logic [`OP_POS-`CFG_INDEX_SIZE-1:0]    pad;
            logic [`CFG_INDEX_SIZE-1:0]            index;
        } renderConfig;
        struct packed {
            logic [`OP_SIZE-1:0]                   opcode;
            logic [`OP_POS-4-1:0]                  pad;
            logic                                  commit;
            logic                                  memset;
            logic                                  selColor;
            logic                                  selDepth;
        } framebuffer;
        struct packed {
            logic [`OP_SIZE-1:0]                   opcode;
            logic [`OP_POS-1:0]                    payload;
        } raw;
    } cmdHeader_u;

    typedef struct packed {
        logic [`CMD_WIDTH-1:0] data;
        logic                  last;
    } streamBeat_t;

    typedef struct packed {
        logic selColor;
        logic selDepth;
        logic commit;
        logic memset;
    } bufferCmd_t;

    typedef struct packed {
        logic [`CMD_WIDTH-1:0] featureEnable;
        logic [`CMD_WIDTH-1:0] fragmentPipe;
        logic [`CMD_WIDTH-1:0] fogColor;
        logic [`CMD_WIDTH-1:0] tmu0TexEnv;
        logic [`CMD_WIDTH-1:0] tmu0TexConfig;
        logic [`CMD_WIDTH-1:0] tmu0TexEnvColor;
        logic [`CMD_WIDTH-1:0] tmu1TexEnv;
        logic [`CMD_WIDTH-1:0] tmu1TexConfig;
        logic [`CMD_WIDTH-1:0] tmu1TexEnvColor;
        logic [`CMD_WIDTH-1:0] scissorStart;
        logic [`CMD_WIDTH-1:0] scissorEnd;
        logic [`CMD_WIDTH-1:0] yOffset;
        logic [`CMD_WIDTH-1:0] clearColor;
        logic [`CMD_WIDTH-1:0] clearDepth;
    } renderConfig_t;

endpackage

// ==== hdl/commandDecoder.sv ====
// Command stream decoder
// Reads header words, forwards payload to the triangle, texture and fog
// streams, and issues config writes, render starts and buffer requests
`timescale 1ns/1ns
`include "rasterCmd_config.svh"

module commandDecoder
(
    input  logic                           aclk,
    input  logic                           resetn,
    input  logic                           cmdValid,
    output logic                           cmdReady,
    input  logic [`CMD_WIDTH-1:0]          cmdData,
    output logic                           triValid,
    input  logic                           triReady,
    output rasterCmdPkg::streamBeat_t      triBeat,
    output logic                           tex0Valid,
    input  logic                           tex0Ready,
    output rasterCmdPkg::streamBeat_t      tex0Beat,
    output logic                           tex1Valid,
    input  logic                           tex1Ready,
    output rasterCmdPkg::streamBeat_t      tex1Beat,
    output logic                           fogValid,
    input  logic                           fogReady,
    output rasterCmdPkg::streamBeat_t      fogBeat,
    input  logic                           rasterizerRunning,
    input  logic                           pixelInPipeline,
    output logic                           startRendering,
    output logic                           cfgWrite,
    output logic [`CFG_INDEX_SIZE-1:0]     cfgIndex,
    output logic [`CMD_WIDTH-1:0]          cfgData,
    output logic                           bufReq,
    output rasterCmdPkg::bufferCmd_t       bufferCmd,
    input  logic                           bufBusy,
    output logic [`TEX_FORMAT_SIZE-1:0]    tex0Format,
    output logic [`TEX_FORMAT_SIZE-1:0]    tex1Format
);
    typedef enum logic [2:0] {sIdle, sHeader, sStream, sConfig, sDrain} state_t;

    localparam logic [1:0] DestTri  = 2'd0;
    localparam logic [1:0] DestTex0 = 2'd1;
    localparam logic [1:0] DestTex1 = 2'd2;
    localparam logic [1:0] DestFog  = 2'd3;

    state_t                    state;
    rasterCmdPkg::cmdHeader_u  header;
    rasterCmdPkg::streamBeat_t outBeat [4];
    logic [3:0]                outValid;
    logic [3:0]                outReady;
    logic [1:0]                dest;
    logic [1:0]                headerDest;
    logic [29:0]               wordsLeft;
    logic [29:0]               headerWords;
    logic [31:0]               texBytes;
    logic                      canStart;
    logic                      headerAccept;
    logic                      beatAccept;
    logic                      lastBeat;

    assign header   = cmdData;
    assign texBytes = 32'd1 << header.texture.sizeLog2;
    assign outReady = {fogReady, tex1Ready, tex0Ready, triReady};

    // Everything downstream must be quiet before the next header
    assign canStart = (state == sIdle) && !startRendering && !rasterizerRunning
                      && !pixelInPipeline && !bufBusy && (outValid == 4'b0);

    always_comb
    begin
        case (state)
            sHeader, sConfig: cmdReady = 1'b1;
            sStream:          cmdReady = !outValid[dest] || outReady[dest];
            default:          cmdReady = 1'b0;
        endcase
    end

    assign headerAccept = (state == sHeader) && cmdValid;
    assign beatAccept   = (state == sStream) && cmdValid && cmdReady;
    assign lastBeat     = (wordsLeft == 30'd1);

    // Payload length in words and target stream for this header
    always_comb
    begin
        headerDest = DestTri;
        case (header.raw.opcode)
            `OP_TRIANGLE:
                headerWords = 30'(header.triangle.byteCount[`TRI_COUNT_SIZE-1:2]);
            `OP_TEXTURE:
            begin
                headerWords = texBytes[31:2];
                headerDest  = header.texture.tmuNr ? DestTex1 : DestTex0;
            end
            `OP_FOG_LUT:
            begin
                headerWords = 30'(`FOG_LUT_WORDS);
                headerDest  = DestFog;
            end
            default:
                headerWords = '0;
        endcase
    end

    assign bufReq             = headerAccept && (header.raw.opcode == `OP_FRAMEBUFFER);
    assign bufferCmd.selColor = header.framebuffer.selColor;
    assign bufferCmd.selDepth = header.framebuffer.selDepth;
    assign bufferCmd.commit   = header.framebuffer.commit;
    assign bufferCmd.memset   = header.framebuffer.memset;

    assign cfgWrite = (state == sConfig) && cmdValid;
    assign cfgData  = cmdData;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state          <= sIdle;
            startRendering <= 1'b0;
            tex0Format     <= '0;
            tex1Format     <= '0;
        end
        else
        begin
            if (startRendering && rasterizerRunning)
                startRendering <= 1'b0;
            case (state)
                sIdle:
                    if (canStart)
                        state <= sHeader;
                sHeader:
                    if (cmdValid)
                    begin
                        case (header.raw.opcode)
                            `OP_TRIANGLE, `OP_FOG_LUT:
                                state <= (headerWords != '0) ? sStream : sIdle;
                            `OP_TEXTURE:
                            begin
                                if (header.texture.tmuNr)
                                    tex1Format <= header.texture.pixelFormat;
                                else
                                    tex0Format <= header.texture.pixelFormat;
                                state <= (headerWords != '0) ? sStream : sIdle;
                            end
                            `OP_RENDER_CONFIG:
                                state <= sConfig;
                            default:
                                state <= sIdle;
                        endcase
                    end
                sStream:
                    if (beatAccept && lastBeat)
                    begin
                        state <= sDrain;
                        if (dest == DestTri)
                            startRendering <= 1'b1;
                    end
                sConfig:
                    if (cmdValid)
                        state <= sIdle;
                sDrain:
                    if (!outValid[dest])
                        state <= sIdle;
                default:
                    state <= sIdle;
            endcase
        end
    end

    // One output register per stream
    always_ff @(posedge aclk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (!resetn)
                outValid[i] <= 1'b0;
            else if (beatAccept && dest == 2'(i))
                outValid[i] <= 1'b1;
            else if (outReady[i])
                outValid[i] <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (beatAccept)
        begin
            outBeat[dest].data <= cmdData;
            outBeat[dest].last <= lastBeat;
        end
        if (headerAccept)
        begin
            dest      <= headerDest;
            wordsLeft <= headerWords;
            cfgIndex  <= header.renderConfig.index;
        end
        else if (beatAccept)
            wordsLeft <= wordsLeft - 30'd1;
    end

    assign triValid  = outValid[DestTri];
    assign triBeat   = outBeat[DestTri];
    assign tex0Valid = outValid[DestTex0];
    assign tex0Beat  = outBeat[DestTex0];
    assign tex1Valid = outValid[DestTex1];
    assign tex1Beat  = outBeat[DestTex1];
    assign fogValid  = outValid[DestFog];
    assign fogBeat   = outBeat[DestFog];

endmodule

// ==== hdl/renderConfigRegs.sv ====
// Render configuration register file
// Fourteen words written by index, presented as one struct
`timescale 1ns/1ns
`include "rasterCmd_config.svh"

module renderConfigRegs
(
    input  logic                          aclk,
    input  logic                          resetn,
    input  logic                          cfgWrite,
    input  logic [`CFG_INDEX_SIZE-1:0]    cfgIndex,
    input  logic [`CMD_WIDTH-1:0]         cfgData,
    output rasterCmdPkg::renderConfig_t   renderConfig
);
    logic [`CMD_WIDTH-1:0] regs [`CFG_REG_COUNT];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            for (int i = 0; i < `CFG_REG_COUNT; i++)
                regs[i] <= '0;
        end
        // Out of range indices are dropped
        else if (cfgWrite && cfgIndex < `CFG_REG_COUNT)
            regs[cfgIndex] <= cfgData;
    end

    assign renderConfig.featureEnable   = regs[`CFG_IDX_FEATURE_ENABLE];
    assign renderConfig.fragmentPipe    = regs[`CFG_IDX_FRAGMENT_PIPE];
    assign renderConfig.fogColor        = regs[`CFG_IDX_FOG_COLOR];
    assign renderConfig.tmu0TexEnv      = regs[`CFG_IDX_TMU0_TEX_ENV];
    assign renderConfig.tmu0TexConfig   = regs[`CFG_IDX_TMU0_TEX_CONFIG];
    assign renderConfig.tmu0TexEnvColor = regs[`CFG_IDX_TMU0_TEX_ENV_COLOR];
    assign renderConfig.tmu1TexEnv      = regs[`CFG_IDX_TMU1_TEX_ENV];
    assign renderConfig.tmu1TexConfig   = regs[`CFG_IDX_TMU1_TEX_CONFIG];
    assign renderConfig.tmu1TexEnvColor = regs[`CFG_IDX_TMU1_TEX_ENV_COLOR];
    assign renderConfig.scissorStart    = regs[`CFG_IDX_SCISSOR_START];
    assign renderConfig.scissorEnd      = regs[`CFG_IDX_SCISSOR_END];
    assign renderConfig.yOffset         = regs[`CFG_IDX_Y_OFFSET];
    assign renderConfig.clearColor      = regs[`CFG_IDX_CLEAR_COLOR];
    assign renderConfig.clearDepth      = regs[`CFG_IDX_CLEAR_DEPTH];

endmodule

// ==== hdl/bufferApplyControl.sv ====
// Buffer apply controller
// Four-phase req/ack sequencer toward the color and depth buffers
`timescale 1ns/1ns

module bufferApplyControl
(
    input  logic                     aclk,
    input  logic                     resetn,
    input  logic                     bufReq,
    input  rasterCmdPkg::bufferCmd_t bufferCmd,
    output logic                     bufBusy,
    output logic                     colorReq,
    input  logic                     colorAck,
    output logic [1:0]               colorCmd,
    output logic                     depthReq,
    input  logic                     depthAck,
    output logic [1:0]               depthCmd
);
    typedef enum logic [1:0] {sIdle, sAwaitHigh, sAwaitLow} state_t;

    state_t                   state;
    rasterCmdPkg::bufferCmd_t cmd;
    logic                     acksHigh;
    logic                     acksLow;

    // Unselected buffers count as done in both phases
    assign acksHigh = (!cmd.selColor || colorAck) && (!cmd.selDepth || depthAck);
    assign acksLow  = (!cmd.selColor || !colorAck) && (!cmd.selDepth || !depthAck);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state    <= sIdle;
            colorReq <= 1'b0;
            depthReq <= 1'b0;
        end
        else
        begin
            case (state)
                sIdle:
                    if (bufReq)
                    begin
                        colorReq <= bufferCmd.selColor;
                        depthReq <= bufferCmd.selDepth;
                        state    <= (bufferCmd.selColor || bufferCmd.selDepth)
                                    ? sAwaitHigh : sAwaitLow;
                    end
                sAwaitHigh:
                    if (acksHigh)
                    begin
                        colorReq <= 1'b0;
                        depthReq <= 1'b0;
                        state    <= sAwaitLow;
                    end
                sAwaitLow:
                    if (acksLow)
                        state <= sIdle;
                default:
                    state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (state == sIdle && bufReq)
            cmd <= bufferCmd;
    end

    assign bufBusy  = (state != sIdle);
    assign colorCmd = {cmd.commit, cmd.memset};
    assign depthCmd = {cmd.commit, cmd.memset};

endmodule

// ==== hdl/rasterCmdTop.sv ====
// Rasterizer command parser top level
// Decoder, render configuration registers and buffer apply controller
`timescale 1ns/1ns

module rasterCmdTop
(
    input  logic                          aclk,
    input  logic                          resetn,
    input  logic                          cmdValid,
    output logic                          cmdReady,
    input  logic [31:0]                   cmdData,
    output logic                          triValid,
    input  logic                          triReady,
    output rasterCmdPkg::streamBeat_t     triBeat,
    output logic                          tex0Valid,
    input  logic                          tex0Ready,
    output rasterCmdPkg::streamBeat_t     tex0Beat,
    output logic                          tex1Valid,
    input  logic                          tex1Ready,
    output rasterCmdPkg::streamBeat_t     tex1Beat,
    output logic                          fogValid,
    input  logic                          fogReady,
    output rasterCmdPkg::streamBeat_t     fogBeat,
    input  logic                          rasterizerRunning,
    input  logic                          pixelInPipeline,
    output logic                          startRendering,
    output rasterCmdPkg::renderConfig_t   renderConfig,
    output logic [4:0]                    tex0Format,
    output logic [4:0]                    tex1Format,
    output logic                          colorReq,
    input  logic                          colorAck,
    output logic [1:0]                    colorCmd,
    output logic                          depthReq,
    input  logic                          depthAck,
    output logic [1:0]                    depthCmd
);
    logic                     cfgWrite;
    logic [3:0]               cfgIndex;
    logic [31:0]              cfgData;
    logic                     bufReq;
    logic                     bufBusy;
    rasterCmdPkg::bufferCmd_t bufferCmd;

    commandDecoder decoder
    (
        .aclk, .resetn,
        .cmdValid, .cmdReady, .cmdData,
        .triValid, .triReady, .triBeat,
        .tex0Valid, .tex0Ready, .tex0Beat,
        .tex1Valid, .tex1Ready, .tex1Beat,
        .fogValid, .fogReady, .fogBeat,
        .rasterizerRunning, .pixelInPipeline, .startRendering,
        .cfgWrite, .cfgIndex, .cfgData,
        .bufReq, .bufferCmd, .bufBusy,
        .tex0Format, .tex1Format
    );

    renderConfigRegs configRegs
    (
        .aclk, .resetn,
        .cfgWrite, .cfgIndex, .cfgData,
        .renderConfig
    );

    bufferApplyControl bufferControl
    (
        .aclk, .resetn,
        .bufReq, .bufferCmd, .bufBusy,
        .colorReq, .colorAck, .colorCmd,
        .depthReq, .depthAck, .depthCmd
    );

endmodule

// ==== dv/rasterCmdTb.sv ====
// Rasterizer command parser testbench
// Drives command words into rasterCmdTop, models the rasterizer, the
// stream sinks and both buffers, and checks every delivered beat
`timescale 1ns/1ns
`include "rasterCmd_config.svh"

// Answers a four-phase request after a short random delay
module bufferResponder
(
    input  logic aclk,
    input  logic req,
    output logic ack
);
    integer seed = 32'h84d2;
    int     delay;

    initial
    begin
        ack = 1'b0;
        forever
        begin
            @(negedge aclk);
            if (req != ack)
            begin
                delay = ($random(seed) & 3) + 1;
                repeat (delay) @(posedge aclk);
                #1;
                ack = req;
            end
        end
    end
endmodule

module rasterCmdTb;
    logic                        aclk = 1'b0;
    logic                        resetn;
    logic                        cmdValid;
    logic                        cmdReady;
    logic [31:0]                 cmdData;
    logic                        triValid, tex0Valid, tex1Valid, fogValid;
    logic                        triReady, tex0Ready, tex1Ready, fogReady;
    rasterCmdPkg::streamBeat_t   triBeat, tex0Beat, tex1Beat, fogBeat;
    logic                        rasterizerRunning;
    logic                        pixelInPipeline;
    logic                        startRendering;
    rasterCmdPkg::renderConfig_t renderConfig;
    logic [4:0]                  tex0Format, tex1Format;
    logic                        colorReq, depthReq, colorAck, depthAck;
    logic [1:0]                  colorCmd, depthCmd;

    integer                      seed = 32'h84d2;
    int                          errorCount = 0;
    int                          checkCount = 0;
    int                          wordsSent = 0;
    int                          renderCount = 0;
    int                          renderExpected = 0;
    logic                        headerPhase = 1'b0;
    logic                        finalWord = 1'b0;
    logic                        colorReqPrev = 1'b0;
    logic                        depthReqPrev = 1'b0;
    logic [31:0]                 readyBits;
    logic [14*32-1:0]            configFlat;
    logic [31:0]                 pendingWords [$];
    rasterCmdPkg::streamBeat_t   expQ [4][$];
    logic [1:0]                  bufExp [2][$];
    logic [31:0]                 cfgModel [`CFG_REG_COUNT];
    logic [4:0]                  texFormat [2];
    string                       streamName [4] = '{"tri", "tex0", "tex1", "fog"};

    rasterCmdTop uut (.*);

    bufferResponder colorBuffer (.aclk, .req(colorReq), .ack(colorAck));
    bufferResponder depthBuffer (.aclk, .req(depthReq), .ack(depthAck));

    assign configFlat = renderConfig;

    always #2 aclk = ~aclk;

    // Sinks accept about three beats in four
    always
    begin
        @(posedge aclk);
        #1;
        readyBits = $random(seed);
        triReady  = readyBits[1:0] != 2'b00;
        tex0Ready = readyBits[3:2] != 2'b00;
        tex1Ready = readyBits[5:4] != 2'b00;
        fogReady  = readyBits[7:6] != 2'b00;
    end

    function void reportRule(input string msg);
        errorCount++;
        $display("%s at %0t ns", msg, $time);
    endfunction

    function void expectEqual(input string name, input logic [31:0] exp, input logic [31:0] got);
        checkCount++;
        assert (got === exp)
        else
        begin
            errorCount++;
            $display("FAIL %s: expected %h, got %h", name, exp, got);
        end
    endfunction

    function void checkBeat(input int s, input rasterCmdPkg::streamBeat_t got);
        rasterCmdPkg::streamBeat_t exp;
        if (expQ[s].size() == 0)
            reportRule({"unexpected beat on the ", streamName[s], " stream"});
        else
        begin
            exp = expQ[s].pop_front();
            expectEqual({streamName[s], "Beat.data"}, exp.data, got.data);
            expectEqual({streamName[s], "Beat.last"}, 32'(exp.last), 32'(got.last));
        end
    endfunction

    function void checkBufferCmd(input int b, input logic [1:0] got);
        if (bufExp[b].size() == 0)
            reportRule(b ? "unexpected depth buffer request" : "unexpected color buffer request");
        else
            expectEqual(b ? "depthCmd" : "colorCmd", 32'(bufExp[b].pop_front()), 32'(got));
    endfunction

    function void checkConfig();
        for (int i = 0; i < `CFG_REG_COUNT; i++)
            expectEqual($sformatf("renderConfig[%0d]", i), cfgModel[i],
                        configFlat[(`CFG_REG_COUNT-1-i)*32 +: 32]);
    endfunction

    function automatic rasterCmdPkg::cmdHeader_u newHeader(input logic [3:0] op);
        newHeader = '0;
        newHeader.raw.opcode = op;
    endfunction

    // Random payload words, also queued as the beats stream s must deliver
    function void queuePayload(input int s, input int n);
        rasterCmdPkg::streamBeat_t b;
        for (int i = 0; i < n; i++)
        begin
            b.data = $random(seed);
            b.last = (i == n - 1);
            pendingWords.push_back(b.data);
            expQ[s].push_back(b);
        end
    endfunction

    function int pendingCount();
        pendingCount = expQ[0].size() + expQ[1].size() + expQ[2].size() + expQ[3].size()
                       + bufExp[0].size() + bufExp[1].size();
    endfunction

    always @(negedge aclk)
    begin
        if (resetn)
        begin
            if (triValid && triReady)
                checkBeat(0, triBeat);
            if (tex0Valid && tex0Ready)
                checkBeat(1, tex0Beat);
            if (tex1Valid && tex1Ready)
                checkBeat(2, tex1Beat);
            if (fogValid && fogReady)
                checkBeat(3, fogBeat);
            if (colorReq && !colorReqPrev)
                checkBufferCmd(0, colorCmd);
            if (depthReq && !depthReqPrev)
                checkBufferCmd(1, depthCmd);
        end
        colorReqPrev = colorReq;
        depthReqPrev = depthReq;
    end

    // Stalled beats hold their value
    assert property (@(posedge aclk) disable iff (!resetn)
        triValid && !triReady |=> triValid && $stable(triBeat))
        else reportRule("tri beat changed or dropped while stalled");
    assert property (@(posedge aclk) disable iff (!resetn)
        tex0Valid && !tex0Ready |=> tex0Valid && $stable(tex0Beat))
        else reportRule("tex0 beat changed or dropped while stalled");
    assert property (@(posedge aclk) disable iff (!resetn)
        tex1Valid && !tex1Ready |=> tex1Valid && $stable(tex1Beat))
        else reportRule("tex1 beat changed or dropped while stalled");
    assert property (@(posedge aclk) disable iff (!resetn)
        fogValid && !fogReady |=> fogValid && $stable(fogBeat))
        else reportRule("fog beat changed or dropped while stalled");

    assert property (@(posedge aclk) disable iff (!resetn)
        headerPhase && cmdValid && cmdReady |-> !startRendering && !rasterizerRunning
            && !pixelInPipeline && !colorReq && !depthReq && !colorAck && !depthAck)
        else reportRule("header accepted while the rasterizer or a buffer was busy");
    assert property (@(posedge aclk) disable iff (!resetn)
        colorReq && !colorAck |=> colorReq)
        else reportRule("color request fell before its ack");
    assert property (@(posedge aclk) disable iff (!resetn)
        depthReq && !depthAck |=> depthReq)
        else reportRule("depth request fell before its ack");
    assert property (@(posedge aclk) disable iff (!resetn)
        $rose(startRendering) |-> $past(cmdValid && cmdReady && finalWord))
        else reportRule("startRendering rose away from the last triangle beat");
    assert property (@(posedge aclk) disable iff (!resetn)
        startRendering && !rasterizerRunning |=> startRendering)
        else reportRule("startRendering fell before the rasterizer ran");
    assert property (@(posedge aclk) disable iff (!resetn)
        startRendering && rasterizerRunning |=> !startRendering)
        else reportRule("startRendering stayed high after the rasterizer ran");

    // Rasterizer runs for a while, pixels drain a little later
    initial
    begin
        rasterizerRunning = 1'b0;
        pixelInPipeline   = 1'b0;
        forever
        begin
            @(negedge aclk);
            if (startRendering && !rasterizerRunning)
            begin
                repeat (3) @(posedge aclk);
                #1;
                rasterizerRunning = 1'b1;
                pixelInPipeline   = 1'b1;
                repeat (6) @(posedge aclk);
                #1;
                rasterizerRunning = 1'b0;
                repeat (2) @(posedge aclk);
                #1;
                pixelInPipeline = 1'b0;
                renderCount++;
            end
        end
    end

    initial
    begin
        while ($time < 40 * wordsSent + 4000)
            @(posedge aclk);
        $display("timeout at %0t ns with %0d words sent", $time, wordsSent);
        $display("sim failed");
        $finish;
    end

    task automatic sendCmd();
        wordsSent += pendingWords.size();
        for (int i = 0; i < pendingWords.size(); i++)
        begin
            cmdValid    = 1'b1;
            cmdData     = pendingWords[i];
            headerPhase = (i == 0);
            finalWord   = (i == pendingWords.size() - 1);
            do
                @(negedge aclk);
            while (!cmdReady);
            @(posedge aclk);
            #1;
        end
        cmdValid    = 1'b0;
        headerPhase = 1'b0;
        finalWord   = 1'b0;
        pendingWords.delete();
    endtask

    task automatic configCmd(input int index, input logic [31:0] value);
        rasterCmdPkg::cmdHeader_u h;
        h = newHeader(`OP_RENDER_CONFIG);
        h.renderConfig.index = 4'(index);
        pendingWords.push_back(h);
        pendingWords.push_back(value);
        if (index < `CFG_REG_COUNT)
            cfgModel[index] = value;
        sendCmd();
        @(negedge aclk);
        checkConfig();
        @(posedge aclk);
        #1;
    endtask

    task automatic triangleCmd(input int beats);
        rasterCmdPkg::cmdHeader_u h;
        h = newHeader(`OP_TRIANGLE);
        h.triangle.byteCount = 18'(4 * beats);
        pendingWords.push_back(h);
        queuePayload(0, beats);
        renderExpected++;
        sendCmd();
    endtask

    task automatic textureCmd(input logic t, input logic [4:0] f, input int s);
        rasterCmdPkg::cmdHeader_u h;
        h = newHeader(`OP_TEXTURE);
        h.texture.tmuNr       = t;
        h.texture.pixelFormat = f;
        h.texture.sizeLog2    = 5'(s);
        pendingWords.push_back(h);
        queuePayload(t ? 2 : 1, (1 << s) / 4);
        texFormat[t] = f;
        sendCmd();
        @(negedge aclk);
        expectEqual("tex0Format", 32'(texFormat[0]), 32'(tex0Format));
        expectEqual("tex1Format", 32'(texFormat[1]), 32'(tex1Format));
        @(posedge aclk);
        #1;
    endtask

    task automatic fogCmd();
        pendingWords.push_back(newHeader(`OP_FOG_LUT));
        queuePayload(3, `FOG_LUT_WORDS);
        sendCmd();
    endtask

    task automatic framebufferCmd(input logic selColor, input logic selDepth,
                                  input logic commit, input logic memset);
        rasterCmdPkg::cmdHeader_u h;
        h = newHeader(`OP_FRAMEBUFFER);
        h.framebuffer.selColor = selColor;
        h.framebuffer.selDepth = selDepth;
        h.framebuffer.commit   = commit;
        h.framebuffer.memset   = memset;
        pendingWords.push_back(h);
        if (selColor)
            bufExp[0].push_back({commit, memset});
        if (selDepth)
            bufExp[1].push_back({commit, memset});
        sendCmd();
    endtask

    // NOP or unknown opcode with junk in the other bits
    task automatic otherCmd(input logic [3:0] op);
        rasterCmdPkg::cmdHeader_u h;
        h = newHeader(op);
        h.raw.payload = 28'($random(seed));
        pendingWords.push_back(h);
        sendCmd();
    endtask

    task automatic waitQuiet();
        do
            @(negedge aclk);
        while (pendingCount() != 0 || colorReq || depthReq || colorAck || depthAck
               || startRendering || rasterizerRunning || pixelInPipeline);
        @(posedge aclk);
        #1;
    endtask

    initial
    begin
        int          pick;
        logic [31:0] arg;
        resetn   = 1'b0;
        cmdValid = 1'b0;
        cmdData  = '0;
        triReady = 1'b0;
        tex0Ready = 1'b0;
        tex1Ready = 1'b0;
        fogReady = 1'b0;
        texFormat = '{5'd0, 5'd0};
        for (int i = 0; i < `CFG_REG_COUNT; i++)
            cfgModel[i] = '0;
        repeat (8) @(posedge aclk);
        #1;
        resetn = 1'b1;

        @(negedge aclk);
        expectEqual("cmdReady", 0, cmdReady);
        expectEqual("triValid", 0, triValid);
        expectEqual("tex0Valid", 0, tex0Valid);
        expectEqual("tex1Valid", 0, tex1Valid);
        expectEqual("fogValid", 0, fogValid);
        expectEqual("startRendering", 0, startRendering);
        expectEqual("colorReq", 0, colorReq);
        expectEqual("depthReq", 0, depthReq);
        checkConfig();
        @(posedge aclk);
        #1;

        configCmd(`CFG_IDX_FEATURE_ENABLE, 32'h0000_00ff);
        configCmd(`CFG_IDX_CLEAR_DEPTH, 32'hdead_beef);
        configCmd(14, 32'h1234_5678);
        configCmd(15, 32'h8765_4321);
        for (int i = 0; i < `CFG_REG_COUNT; i++)
            configCmd(i, $random(seed));

        triangleCmd(1);
        triangleCmd(5);
        triangleCmd(12);

        textureCmd(1'b0, 5'h0a, 4);
        textureCmd(1'b1, 5'h13, 6);
        textureCmd(1'b0, 5'h1f, 0);
        textureCmd(1'b1, 5'h05, 2);

        fogCmd();
        fogCmd();

        for (int i = 0; i < 16; i++)
            framebufferCmd(i[3], i[2], i[1], i[0]);

        otherCmd(`OP_NOP);
        otherCmd(4'hf);

        // Mixed traffic of every command kind
        for (int i = 0; i < 24; i++)
        begin
            pick = $unsigned($random(seed)) % 7;
            arg  = $random(seed);
            case (pick)
                0: triangleCmd(int'(arg[2:0]) + 1);
                1: textureCmd(arg[0], arg[8:4], int'(arg[2:1]) * 2);
                2: fogCmd();
                3: configCmd(int'(arg[3:0]), $random(seed));
                4: framebufferCmd(arg[0], arg[1], arg[2], arg[3]);
                5: otherCmd(`OP_NOP);
                default: otherCmd(4'(6 + arg[2:0]));
            endcase
        end

        waitQuiet();
        expectEqual("renderCount", renderExpected, renderCount);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== rasterCmd.f ====
+incdir+hdl
hdl/rasterCmdPkg.sv
hdl/commandDecoder.sv
hdl/renderConfigRegs.sv
hdl/bufferApplyControl.sv
hdl/rasterCmdTop.sv
dv/rasterCmdTb.sv

// ==== Bender.yml ====
package:
  name: rasterCmd

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rasterCmdPkg.sv
      - hdl/commandDecoder.sv
      - hdl/renderConfigRegs.sv
      - hdl/bufferApplyControl.sv
      - hdl/rasterCmdTop.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/rasterCmdTb.sv
